//--- source/wb_macros.svh
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// Bus widths
`define WB_DATA_W 32
`define WB_ADDR_W 32
`define WB_SEL_W 4

// SRAM depth in words, indexed by address bits 9:2
`define WB_MEM_WORDS 256

// Pipeline stall vector
`define STALL_W 6
`define STALL_MEM 4 // Stops the memory stage and everything before it

// Slave wait-state setting
`define WAIT_W 2

`endif

//--- source/wb_pkg.sv
`include "wb_macros.svh"

package wb_pkg;

	typedef logic [`WB_DATA_W-1:0] word_t; // One data word
	typedef logic [`WB_ADDR_W-1:0] addr_t; // Byte address
	typedef logic [`WB_SEL_W-1:0] sel_t; // One bit per byte lane
	typedef logic [`STALL_W-1:0] stall_t; // Bit n stops stage n and all earlier

	// Bus interface FSM
	typedef enum logic [1:0] {
		WB_IDLE = 2'd0,
		WB_BUSY = 2'd1,
		WB_WAIT_FOR_STALL = 2'd2
	} wb_state_t;

	// Memory stage FSM
	typedef enum logic [1:0] {
		MS_EMPTY = 2'd0,
		MS_ISSUE = 2'd1,
		MS_DONE = 2'd2
	} mem_state_t;

endpackage

//--- source/stall_ctrl.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module stall_ctrl (
	input logic clk,
	input logic reset_i,
	input logic stallreq_i, // From the bus interface
	input logic hold_i, // From the later pipeline
	input logic flush_i,
	output wb_pkg::stall_t stall_o
);

	import wb_pkg::*;

	// Memory stage and everything before it
	localparam stall_t MEM_MASK = stall_t'((1 << (`STALL_MEM + 1)) - 1);
	// One stage further down the pipeline
	localparam stall_t HOLD_MASK = stall_t'((1 << (`STALL_MEM + 2)) - 1);

	logic flush_q; // Flush seen last cycle
	stall_t req_vec;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			flush_q <= 1'b0;
		end else begin
			flush_q <= flush_i;
		end
	end

	always_comb begin
		req_vec = '0;
		if (stallreq_i) begin
			req_vec = req_vec | MEM_MASK;
		end
		if (hold_i) begin
			req_vec = req_vec | HOLD_MASK;
		end
	end

	// Flushed stages get one free cycle to restart
	assign stall_o = flush_q ? '0 : req_vec;

endmodule

//--- source/mem_stage.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module mem_stage (
	input logic clk,
	input logic reset_i,
	// Command port
	input logic cmd_valid_i,
	input logic cmd_we_i,
	input wb_pkg::addr_t cmd_addr_i,
	input wb_pkg::word_t cmd_wdata_i,
	input wb_pkg::sel_t cmd_sel_i,
	output logic cmd_ready_o,
	// Pipeline control
	input wb_pkg::stall_t stall_i,
	input logic flush_i,
	// Bus interface side
	input wb_pkg::word_t mmu_rdata_i,
	input logic mmu_ack_i,
	output logic mmu_ce_o,
	output logic mmu_we_o,
	output wb_pkg::addr_t mmu_addr_o,
	output wb_pkg::word_t mmu_wdata_o,
	output wb_pkg::sel_t mmu_sel_o,
	// Response port
	output logic rsp_valid_o,
	output wb_pkg::word_t rsp_rdata_o
);

	import wb_pkg::*;

	mem_state_t state;
	logic we_q;
	addr_t addr_q;
	word_t wdata_q;
	sel_t sel_q;
	word_t rdata_q; // Result of the last access

	logic accept;

	// A set memory stall bit also covers hold, which sets every lower bit
	assign accept = cmd_valid_i && cmd_ready_o;
	assign cmd_ready_o = (state == MS_EMPTY) && !stall_i[`STALL_MEM];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= MS_EMPTY;
		end else begin
			case (state)
				MS_EMPTY: begin
					if (accept) begin
						state <= MS_ISSUE;
					end
				end
				MS_ISSUE: begin
					if (mmu_ack_i) begin // Ack wins over a late flush
						state <= MS_DONE;
					end else if (flush_i) begin
						state <= MS_EMPTY; // Access abandoned, no response
					end
				end
				MS_DONE: begin
					if (!stall_i[`STALL_MEM]) begin
						state <= MS_EMPTY;
					end
				end
				default: state <= MS_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			we_q <= cmd_we_i;
			addr_q <= cmd_addr_i;
			wdata_q <= cmd_wdata_i;
			sel_q <= cmd_sel_i;
		end
		if (state == MS_ISSUE && mmu_ack_i) begin
			rdata_q <= we_q ? '0 : mmu_rdata_i; // Stores answer with zero
		end
	end

	// Request held stable until the ack
	assign mmu_ce_o = (state == MS_ISSUE);
	assign mmu_we_o = we_q;
	assign mmu_addr_o = addr_q;
	assign mmu_wdata_o = wdata_q;
	assign mmu_sel_o = sel_q;

	assign rsp_valid_o = (state == MS_DONE) && !stall_i[`STALL_MEM];
	assign rsp_rdata_o = rdata_q;

endmodule

//--- source/wishbone_bus_if.sv
`timescale 1ns/1ps

module wishbone_bus_if (
	input logic clk,
	input logic reset_i,
	// Pipeline control
	input wb_pkg::stall_t stall_i,
	input logic flush_i,
	// Memory stage side
	input logic mmu_ce_i,
	input logic mmu_we_i,
	input wb_pkg::addr_t mmu_addr_i,
	input wb_pkg::word_t mmu_data_i,
	input wb_pkg::sel_t mmu_select_i,
	output wb_pkg::word_t mmu_data_o,
	output logic mmu_ack_o,
	// Wishbone side
	input wb_pkg::word_t wishbone_data_i,
	input logic wishbone_ack_i,
	output logic wishbone_cyc_o,
	output logic wishbone_stb_o,
	output wb_pkg::addr_t wishbone_addr_o,
	output wb_pkg::word_t wishbone_data_o,
	output logic wishbone_we_o,
	output wb_pkg::sel_t wishbone_select_o,
	// To the stall controller
	output logic stallreq_o
);

	import wb_pkg::*;

	wb_state_t state;
	word_t rd_buf; // Read data kept for the stall wait

	logic start;
	logic bus_ack;

	assign start = (state == WB_IDLE) && mmu_ce_i && !flush_i;
	assign bus_ack = (state == WB_BUSY) && wishbone_ack_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= WB_IDLE;
			wishbone_we_o <= 1'b0;
			wishbone_select_o <= '0;
		end else begin
			case (state)
				WB_IDLE: begin
					if (start) begin
						wishbone_we_o <= mmu_we_i;
						wishbone_select_o <= mmu_select_i;
						state <= WB_BUSY;
					end
				end
				WB_BUSY: begin
					if (wishbone_ack_i) begin
						wishbone_we_o <= 1'b0;
						wishbone_select_o <= '0;
						if (stall_i != '0) begin
							state <= WB_WAIT_FOR_STALL; // Pipeline not ready for the data
						end else begin
							state <= WB_IDLE;
						end
					end else if (flush_i) begin
						wishbone_we_o <= 1'b0;
						wishbone_select_o <= '0;
						state <= WB_IDLE; // Drop the cycle
					end
				end
				WB_WAIT_FOR_STALL: begin
					if (stall_i == '0) begin
						state <= WB_IDLE;
					end
				end
				default: state <= WB_IDLE;
			endcase
		end
	end

	// Address and write data carry no control meaning
	always_ff @(posedge clk) begin
		if (start) begin
			wishbone_addr_o <= mmu_addr_i;
			wishbone_data_o <= mmu_data_i;
		end else if (bus_ack || (state == WB_BUSY && flush_i)) begin
			wishbone_addr_o <= '0;
			wishbone_data_o <= '0;
		end
		if (bus_ack && !wishbone_we_o) begin
			rd_buf <= wishbone_data_i;
		end
	end

	assign wishbone_cyc_o = (state == WB_BUSY);
	assign wishbone_stb_o = (state == WB_BUSY);
	assign mmu_ack_o = bus_ack;

	always_comb begin
		mmu_data_o = '0;
		stallreq_o = 1'b0;
		case (state)
			WB_IDLE: stallreq_o = start;
			WB_BUSY: begin
				stallreq_o = !wishbone_ack_i; // Hold the pipe until the slave answers
				if (wishbone_ack_i && !wishbone_we_o) begin
					mmu_data_o = wishbone_data_i;
				end
			end
			WB_WAIT_FOR_STALL: mmu_data_o = rd_buf;
			default: mmu_data_o = '0;
		endcase
	end

endmodule

//--- source/wb_sram.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module wb_sram (
	input logic clk,
	input logic reset_i,
	input logic [`WAIT_W-1:0] wait_states_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input wb_pkg::addr_t wb_adr_i,
	input wb_pkg::word_t wb_dat_i,
	input wb_pkg::sel_t wb_sel_i,
	output wb_pkg::word_t wb_dat_o,
	output logic wb_ack_o
);

	import wb_pkg::*;

	localparam int IDX_W = $clog2(`WB_MEM_WORDS);

	word_t mem [`WB_MEM_WORDS];

	logic clearing; // Zero fill after reset
	logic [IDX_W-1:0] clr_idx;
	logic [`WAIT_W-1:0] wait_cnt;
	logic [IDX_W-1:0] word_idx;
	logic req;

	assign word_idx = wb_adr_i[IDX_W+1:2]; // Word address, upper bits ignored
	assign req = wb_cyc_i && wb_stb_i && !clearing;

	// An access during the fill simply waits for it
	assign wb_ack_o = req && (wait_cnt == wait_states_i);
	assign wb_dat_o = wb_ack_o ? mem[word_idx] : '0;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			clearing <= 1'b1;
			clr_idx <= '0;
			wait_cnt <= '0;
		end else begin
			if (clearing) begin
				clr_idx <= clr_idx + 1'b1;
				if (clr_idx == IDX_W'(`WB_MEM_WORDS - 1)) begin
					clearing <= 1'b0;
				end
			end
			if (req && !wb_ack_o) begin
				wait_cnt <= wait_cnt + 1'b1;
			end else begin
				wait_cnt <= '0; // Restart after ack or dropped strobe
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clearing) begin
			mem[clr_idx] <= '0;
		end else if (wb_ack_o && wb_we_i) begin
			for (int b = 0; b < `WB_SEL_W; b++) begin
				if (wb_sel_i[b]) begin
					mem[word_idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
				end
			end
		end
	end

endmodule

//--- source/mem_subsystem_top.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module mem_subsystem_top (
	input logic clk,
	input logic reset_i,
	input logic cmd_valid_i,
	input logic cmd_we_i,
	input wb_pkg::addr_t cmd_addr_i,
	input wb_pkg::word_t cmd_wdata_i,
	input wb_pkg::sel_t cmd_sel_i,
	output logic cmd_ready_o,
	output logic rsp_valid_o,
	output wb_pkg::word_t rsp_rdata_o,
	input logic hold_i,
	input logic flush_i,
	input logic [`WAIT_W-1:0] wait_states_i
);

	import wb_pkg::*;

	stall_t stall;
	logic stallreq;

	// Memory stage to bus interface
	logic mmu_ce;
	logic mmu_we;
	addr_t mmu_addr;
	word_t mmu_wdata;
	sel_t mmu_sel;
	word_t mmu_rdata;
	logic mmu_ack;

	// Wishbone
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	addr_t wb_adr;
	word_t wb_dat_w;
	sel_t wb_sel;
	word_t wb_dat_r;
	logic wb_ack;

	stall_ctrl u_stall_ctrl (
		.clk(clk),
		.reset_i(reset_i),
		.stallreq_i(stallreq),
		.hold_i(hold_i),
		.flush_i(flush_i),
		.stall_o(stall)
	);

	mem_stage u_mem_stage (
		.clk(clk),
		.reset_i(reset_i),
		.cmd_valid_i(cmd_valid_i),
		.cmd_we_i(cmd_we_i),
		.cmd_addr_i(cmd_addr_i),
		.cmd_wdata_i(cmd_wdata_i),
		.cmd_sel_i(cmd_sel_i),
		.cmd_ready_o(cmd_ready_o),
		.stall_i(stall),
		.flush_i(flush_i),
		.mmu_rdata_i(mmu_rdata),
		.mmu_ack_i(mmu_ack),
		.mmu_ce_o(mmu_ce),
		.mmu_we_o(mmu_we),
		.mmu_addr_o(mmu_addr),
		.mmu_wdata_o(mmu_wdata),
		.mmu_sel_o(mmu_sel),
		.rsp_valid_o(rsp_valid_o),
		.rsp_rdata_o(rsp_rdata_o)
	);

	wishbone_bus_if u_wishbone_bus_if (
		.clk(clk),
		.reset_i(reset_i),
		.stall_i(stall),
		.flush_i(flush_i),
		.mmu_ce_i(mmu_ce),
		.mmu_we_i(mmu_we),
		.mmu_addr_i(mmu_addr),
		.mmu_data_i(mmu_wdata),
		.mmu_select_i(mmu_sel),
		.mmu_data_o(mmu_rdata),
		.mmu_ack_o(mmu_ack),
		.wishbone_data_i(wb_dat_r),
		.wishbone_ack_i(wb_ack),
		.wishbone_cyc_o(wb_cyc),
		.wishbone_stb_o(wb_stb),
		.wishbone_addr_o(wb_adr),
		.wishbone_data_o(wb_dat_w),
		.wishbone_we_o(wb_we),
		.wishbone_select_o(wb_sel),
		.stallreq_o(stallreq)
	);

	wb_sram u_wb_sram (
		.clk(clk),
		.reset_i(reset_i),
		.wait_states_i(wait_states_i),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_sel_i(wb_sel),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack)
	);

endmodule

//--- verif/wb_bus_checker.sv
`timescale 1ns/1ps

module wb_bus_checker (
	input logic clk,
	input logic reset_i,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic we_i,
	input wb_pkg::addr_t adr_i,
	input wb_pkg::word_t dat_i,
	input wb_pkg::sel_t sel_i,
	input logic stallreq_i
);

	bit cyc_err;
	bit hold_err;
	bit ack_err;
	bit stall_err;
	logic any_fail; // Sampled by the testbench

	assign any_fail = cyc_err | hold_err | ack_err | stall_err;

	cyc_matches_stb: assert property (@(posedge clk) disable iff (reset_i) cyc_i == stb_i)
		else begin
			cyc_err = 1'b1;
			$error("cyc and stb differ");
		end

	// Request frozen from one strobe cycle to the next until the ack
	req_stable: assert property (@(posedge clk) disable iff (reset_i)
		(stb_i && $past(stb_i) && !$past(ack_i)) |->
		(adr_i == $past(adr_i) && dat_i == $past(dat_i) && we_i == $past(we_i) &&
		sel_i == $past(sel_i)))
		else begin
			hold_err = 1'b1;
			$error("Request changed while waiting for ack");
		end

	ack_needs_stb: assert property (@(posedge clk) disable iff (reset_i) ack_i |-> stb_i)
		else begin
			ack_err = 1'b1;
			$error("ack without stb");
		end

	stall_while_pending: assert property (@(posedge clk) disable iff (reset_i)
		(stb_i && !ack_i) |-> stallreq_i)
		else begin
			stall_err = 1'b1;
			$error("No stall request during a pending access");
		end

endmodule

bind wishbone_bus_if wb_bus_checker u_checker (
	.clk(clk),
	.reset_i(reset_i),
	.cyc_i(wishbone_cyc_o),
	.stb_i(wishbone_stb_o),
	.ack_i(wishbone_ack_i),
	.we_i(wishbone_we_o),
	.adr_i(wishbone_addr_o),
	.dat_i(wishbone_data_o),
	.sel_i(wishbone_select_o),
	.stallreq_i(stallreq_o)
);

//--- verif/mem_subsystem_tb.sv
`timescale 1ns/1ps
`include "wb_macros.svh"

module mem_subsystem_tb;

	import wb_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int IDX_W = $clog2(`WB_MEM_WORDS);
	localparam int MAX_WAIT = (1 << `WAIT_W) - 1;
	localparam int MAX_HOLD = 10; // Hold delay plus hold length per command
	localparam int N_ZERO = 8;
	localparam int N_WORDS = 8; // Words written per wait setting
	localparam int N_MERGE = 32;
	localparam int N_HOLD = 64;
	localparam int N_FLUSH = 8;
	localparam int N_CMDS = N_ZERO + 2 * N_WORDS * (MAX_WAIT + 1) + N_MERGE + N_HOLD + 3 * N_FLUSH;
	localparam int TIMEOUT = N_CMDS * (6 + MAX_WAIT + MAX_HOLD) + `WB_MEM_WORDS + RESET_CYCLES;

	logic clk;
	logic reset;
	logic cmd_valid;
	logic cmd_we;
	addr_t cmd_addr;
	word_t cmd_wdata;
	sel_t cmd_sel;
	logic cmd_ready;
	logic rsp_valid;
	word_t rsp_rdata;
	logic hold;
	logic flush;
	logic [`WAIT_W-1:0] wait_states;

	word_t model [`WB_MEM_WORDS]; // Expected SRAM contents
	word_t exp_q [$]; // Expected responses in order
	int issued = 0;
	int rsp_count = 0;
	int cycles = 0;

	mem_subsystem_top dut (
		.clk(clk),
		.reset_i(reset),
		.cmd_valid_i(cmd_valid),
		.cmd_we_i(cmd_we),
		.cmd_addr_i(cmd_addr),
		.cmd_wdata_i(cmd_wdata),
		.cmd_sel_i(cmd_sel),
		.cmd_ready_o(cmd_ready),
		.rsp_valid_o(rsp_valid),
		.rsp_rdata_o(rsp_rdata),
		.hold_i(hold),
		.flush_i(flush),
		.wait_states_i(wait_states)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED at %0t: %s got %08h expected %08h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			stop_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, what, got, exp));
		end
	endtask

	// Word index in bits 9:2, random upper bits that the SRAM ignores
	function automatic addr_t make_addr(input int idx);
		addr_t a;
		a = addr_t'($urandom);
		a[IDX_W+1:2] = idx[IDX_W-1:0];
		a[1:0] = 2'b00;
		return a;
	endfunction

	// Applies a store to the model, returns what the response should carry
	function automatic word_t model_access(input logic we, input addr_t addr,
		input word_t wdata, input sel_t sel);
		int idx;
		int b;
		word_t merged;
		idx = int'(addr[IDX_W+1:2]);
		merged = model[idx];
		if (!we) begin
			return merged;
		end
		for (b = 0; b < `WB_SEL_W; b++) begin
			if (sel[b]) begin
				merged[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		model[idx] = merged;
		return '0;
	endfunction

	// Returns on the edge that completes the handshake
	task automatic present_cmd(input logic we, input addr_t addr, input word_t wdata,
		input sel_t sel);
		cmd_valid <= 1'b1;
		cmd_we <= we;
		cmd_addr <= addr;
		cmd_wdata <= wdata;
		cmd_sel <= sel;
		do begin
			@(posedge clk);
		end while (!cmd_ready);
		cmd_valid <= 1'b0;
	endtask

	task automatic run_cmd(input logic we, input addr_t addr, input word_t wdata,
		input sel_t sel, input int hold_dly, input int hold_len);
		int c;
		logic seen;
		c = 0;
		seen = 1'b0;
		present_cmd(we, addr, wdata, sel);
		exp_q.push_back(model_access(we, addr, wdata, sel));
		issued++;
		while (!seen || c < hold_dly + hold_len) begin
			hold <= (c >= hold_dly) && (c < hold_dly + hold_len); // Window may cover the ack
			@(posedge clk);
			c++;
			if (rsp_valid) begin
				seen = 1'b1;
			end
		end
		hold <= 1'b0;
	endtask

	// Needs at least one wait state so the first strobe cycle has no ack
	task automatic run_flushed_write(input addr_t addr, input word_t wdata, input sel_t sel);
		present_cmd(1'b1, addr, wdata, sel);
		@(posedge clk); // Bus interface sees mmu_ce here
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		check_flag(dut.wb_stb, 1'b1, "strobe during flush");
		check_flag(dut.wb_ack, 1'b0, "ack during flush");
		repeat (4 + MAX_WAIT) @(posedge clk);
		check_flag(dut.wb_stb, 1'b0, "strobe after flush");
		check_flag(cmd_ready, 1'b1, "ready after flush");
	endtask

	always @(posedge clk) begin
		if (!reset && rsp_valid) begin
			if (exp_q.size() == 0) begin
				// Every accepted command already answered
				check_count(rsp_count + 1, issued, "responses against accepted commands");
			end else begin
				check_word(rsp_rdata, exp_q.pop_front(), $sformatf("response %0d", rsp_count));
				rsp_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			stop_run($sformatf("Timeout: the run did not finish within %0d cycles", TIMEOUT));
		end
		if (dut.u_wishbone_bus_if.u_checker.any_fail) begin
			stop_run("A bus protocol assertion failed");
		end
	end

	initial begin
		int idx;
		logic we;
		word_t data;
		sel_t sel;
		addr_t addrs [N_WORDS];
		void'($urandom(60));
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_we = 1'b0;
		cmd_addr = '0;
		cmd_wdata = '0;
		cmd_sel = '0;
		hold = 1'b0;
		flush = 1'b0;
		wait_states = '0;
		foreach (model[i]) begin
			model[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		do begin
			@(posedge clk);
		end while (!cmd_ready);

		// Fresh memory reads zero, first read waits out the clear
		for (int i = 0; i < N_ZERO; i++) begin
			run_cmd(1'b0, make_addr($urandom % `WB_MEM_WORDS), '0, '1, 0, 0);
		end

		for (int w = 0; w <= MAX_WAIT; w++) begin
			wait_states <= `WAIT_W'(w);
			for (int i = 0; i < N_WORDS; i++) begin
				addrs[i] = make_addr(w * N_WORDS + i);
				data = word_t'($urandom);
				run_cmd(1'b1, addrs[i], data, '1, 0, 0);
			end
			for (int i = 0; i < N_WORDS; i++) begin
				run_cmd(1'b0, addrs[i], '0, '1, 0, 0);
			end
		end

		// Few words so partial stores pile up on each other
		for (int i = 0; i < N_MERGE; i++) begin
			wait_states <= `WAIT_W'($urandom);
			idx = 40 + int'($urandom % 4);
			we = ($urandom % 2) == 0;
			data = word_t'($urandom);
			sel = sel_t'($urandom);
			run_cmd(we, make_addr(idx), data, sel, 0, 0);
		end

		for (int i = 0; i < N_HOLD; i++) begin
			wait_states <= `WAIT_W'($urandom);
			idx = 64 + int'($urandom % 8);
			we = ($urandom % 2) == 0;
			data = word_t'($urandom);
			sel = sel_t'($urandom);
			run_cmd(we, make_addr(idx), data, sel, int'($urandom % (MAX_WAIT + 3)),
				1 + int'($urandom % 4));
		end

		for (int i = 0; i < N_FLUSH; i++) begin
			wait_states <= `WAIT_W'(1 + ($urandom % MAX_WAIT));
			idx = 96 + i;
			data = word_t'($urandom);
			run_cmd(1'b1, make_addr(idx), data, '1, 0, 0);
			data = word_t'($urandom);
			sel = sel_t'($urandom);
			run_flushed_write(make_addr(idx), data, sel);
			run_cmd(1'b0, make_addr(idx), '0, '1, 0, 0); // Old word must survive
		end

		repeat (2) @(posedge clk);
		if (dut.u_wishbone_bus_if.u_checker.any_fail) begin
			stop_run("A bus protocol assertion failed");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

//--- project.f
+incdir+source
source/wb_pkg.sv
source/stall_ctrl.sv
source/mem_stage.sv
source/wishbone_bus_if.sv
source/wb_sram.sv
source/mem_subsystem_top.sv
verif/wb_bus_checker.sv
verif/mem_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= mem_subsystem_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+10
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
